// ==== common/dm_pkg.sv ====
package dm_pkg;

  // hart count and derived select width
  localparam int unsigned NrHarts  = 2;
  localparam int unsigned HartSelW = (NrHarts > 1) ? $clog2(NrHarts) : 1;

  typedef enum logic [1:0] {
    DtmNop   = 2'h0,
    DtmRead  = 2'h1,
    DtmWrite = 2'h2
  } dtm_op_e;

  // dmi register map
  localparam logic [6:0] Data0Addr      = 7'h04;
  localparam logic [6:0] DmControlAddr  = 7'h10;
  localparam logic [6:0] DmStatusAddr   = 7'h11;
  localparam logic [6:0] SbcsAddr       = 7'h38;
  localparam logic [6:0] SbAddress0Addr = 7'h39;
  localparam logic [6:0] SbData0Addr    = 7'h3c;

  // hart-facing slave window
  localparam logic [31:0] HaltedAddr   = 32'h0000_0100; // hart writes its id on halt
  localparam logic [31:0] ResumingAddr = 32'h0000_0108; // hart writes its id on resume
  localparam logic [31:0] FlagsAddr    = 32'h0000_0400; // going bits, one per hart

  localparam logic [3:0] DmVersion  = 4'd2;  // debug spec 0.13
  localparam logic [2:0] SbVersion  = 3'd1;
  localparam logic [2:0] SbAccess32 = 3'd2;  // only word accesses
  localparam logic [2:0] SbErrBus   = 3'd2;  // bad address or bus error
  localparam logic [1:0] DmiRespOk  = 2'd0;

  typedef struct packed {
    logic [6:0]  addr;
    dtm_op_e     op;
    logic [31:0] data;
  } dmi_req_t;

  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } dmi_resp_t;

  // command from the csr block to the bus master
  typedef struct packed {
    logic [31:0] address;
    logic [31:0] wdata;
    logic        write;
    logic        start;
  } sb_cmd_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        rdata_valid; // one cycle per completed read
    logic        busy;
    logic [2:0]  error;       // nonzero for one cycle on a failed access
  } sb_status_t;

endpackage

// ==== csrs/dm_csrs.sv ====
`timescale 1ns/100ps

module dm_csrs (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              dmi_req_valid_i,
  output logic                              dmi_req_ready_o,
  input  dm_pkg::dmi_req_t                  dmi_req_i,
  output logic                              dmi_resp_valid_o,
  input  logic                              dmi_resp_ready_i,
  output dm_pkg::dmi_resp_t                 dmi_resp_o,
  output logic                              dmactive_o,
  output logic [dm_pkg::HartSelW-1:0]       hartsel_o,
  output logic                              haltreq_o,
  output logic                              resumereq_o,
  input  logic [dm_pkg::NrHarts-1:0]        halted_i,
  input  logic [dm_pkg::NrHarts-1:0]        resumeack_i,
  output dm_pkg::sb_cmd_t                   sb_cmd_o,
  input  dm_pkg::sb_status_t                sb_status_i
);
  import dm_pkg::*;

  logic                req_fire, is_write, is_read, sb_idle;
  logic [31:0]         wdata, rdata, dmstatus, sbcs;
  logic                resp_valid_q;
  dmi_resp_t           resp_q;
  logic                dmactive_q, haltreq_q, resumereq_q;
  logic [HartSelW-1:0] hartsel_q;
  logic [31:0]         data0_q, sbaddr_q, sbdata_q;
  logic                sbreadonaddr_q, sbreadondata_q;
  logic [2:0]          sberror_q;
  logic                sb_start_q, sb_write_q;

  assign dmi_req_ready_o = ~resp_valid_q; // one response in flight
  assign req_fire = dmi_req_valid_i & dmi_req_ready_o;
  assign is_write = req_fire & (dmi_req_i.op == DtmWrite);
  assign is_read  = req_fire & (dmi_req_i.op == DtmRead);
  assign wdata    = dmi_req_i.data;

  // new bus access only when nothing is running and no error is pending
  assign sb_idle = dmactive_q & ~sb_status_i.busy & ~sb_start_q & (sberror_q == 3'd0);

  always_comb begin
    dmstatus        = '0;
    dmstatus[3:0]   = DmVersion;
    dmstatus[7]     = 1'b1; // authenticated
    dmstatus[9:8]   = {2{halted_i[hartsel_q]}};
    dmstatus[11:10] = {2{~halted_i[hartsel_q]}};
    dmstatus[17:16] = {2{resumeack_i[hartsel_q]}};

    sbcs            = '0;
    sbcs[31:29]     = SbVersion;
    sbcs[21]        = sb_status_i.busy | sb_start_q;
    sbcs[20]        = sbreadonaddr_q;
    sbcs[19:17]     = SbAccess32;
    sbcs[15]        = sbreadondata_q;
    sbcs[14:12]     = sberror_q;
    sbcs[11:5]      = 7'd32; // sbasize
    sbcs[2]         = 1'b1;  // sbaccess32

    case (dmi_req_i.addr)
      Data0Addr:      rdata = data0_q;
      DmControlAddr:  rdata = {haltreq_q, 5'b0, {(10 - HartSelW){1'b0}}, hartsel_q,
                               15'b0, dmactive_q};
      DmStatusAddr:   rdata = dmstatus;
      SbcsAddr:       rdata = sbcs;
      SbAddress0Addr: rdata = sbaddr_q;
      SbData0Addr:    rdata = sbdata_q;
      default:        rdata = '0; // unmapped reads as zero
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= 1'b0;
    end else if (req_fire) begin
      resp_valid_q <= 1'b1;
    end else if (dmi_resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      resp_q.data <= (dmi_req_i.op == DtmRead) ? rdata : 32'd0;
      resp_q.resp <= DmiRespOk;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dmactive_q     <= 1'b0;
      haltreq_q      <= 1'b0;
      resumereq_q    <= 1'b0;
      hartsel_q      <= '0;
      data0_q        <= '0;
      sbaddr_q       <= '0;
      sbdata_q       <= '0;
      sbreadonaddr_q <= 1'b0;
      sbreadondata_q <= 1'b0;
      sberror_q      <= 3'd0;
      sb_start_q     <= 1'b0;
      sb_write_q     <= 1'b0;
    end else begin
      resumereq_q <= 1'b0;
      sb_start_q  <= 1'b0;
      if (is_write) begin
        case (dmi_req_i.addr)
          Data0Addr: data0_q <= wdata;
          DmControlAddr: begin
            dmactive_q  <= wdata[0];
            haltreq_q   <= wdata[31] & wdata[0];
            resumereq_q <= wdata[30] & wdata[0];
            hartsel_q   <= wdata[16 +: HartSelW];
          end
          SbcsAddr: begin
            sbreadonaddr_q <= wdata[20];
            sbreadondata_q <= wdata[15];
            sberror_q      <= sberror_q & ~wdata[14:12]; // write 1 to clear
          end
          SbAddress0Addr: begin
            sbaddr_q <= wdata;
            if (sbreadonaddr_q && sb_idle) begin
              sb_start_q <= 1'b1;
              sb_write_q <= 1'b0;
            end
          end
          SbData0Addr: begin
            if (sb_idle) begin
              sbdata_q   <= wdata;
              sb_start_q <= 1'b1;
              sb_write_q <= 1'b1;
            end
          end
          default: ;
        endcase
      end
      // response already holds the old data, fetch the next word
      if (is_read && dmi_req_i.addr == SbData0Addr && sbreadondata_q && sb_idle) begin
        sb_start_q <= 1'b1;
        sb_write_q <= 1'b0;
      end
      if (sb_status_i.rdata_valid) sbdata_q <= sb_status_i.rdata;
      if (sb_status_i.error != 3'd0) sberror_q <= sb_status_i.error;
    end
  end

  assign dmi_resp_valid_o = resp_valid_q;
  assign dmi_resp_o       = resp_q;
  assign dmactive_o       = dmactive_q;
  assign hartsel_o        = hartsel_q;
  assign haltreq_o        = haltreq_q;
  assign resumereq_o      = resumereq_q;
  assign sb_cmd_o = '{address: sbaddr_q, wdata: sbdata_q, write: sb_write_q, start: sb_start_q};

  // dtm may stall the response, payload must not move meanwhile
  a_resp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dmi_resp_valid_o && !dmi_resp_ready_i |=> dmi_resp_valid_o && $stable(dmi_resp_o));

endmodule

// ==== sba/dm_sba.sv ====
`timescale 1ns/100ps

module dm_sba (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               dmactive_i,
  input  dm_pkg::sb_cmd_t    sb_cmd_i,
  output dm_pkg::sb_status_t sb_status_o,
  output logic               master_req_o,
  output logic [31:0]        master_add_o,
  output logic               master_we_o,
  output logic [31:0]        master_wdata_o,
  input  logic               master_gnt_i,
  input  logic               master_r_valid_i,
  input  logic               master_r_err_i,
  input  logic [31:0]        master_r_rdata_i
);
  import dm_pkg::*;

  typedef enum logic [1:0] {
    SbIdle,
    SbReq,
    SbWait
  } sb_state_e;

  sb_state_e   state_q;
  logic [31:0] addr_q, wdata_q, rdata_q;
  logic        we_q;
  logic        rdata_valid_q;
  logic [2:0]  error_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q       <= SbIdle;
      rdata_valid_q <= 1'b0;
      error_q       <= 3'd0;
    end else begin
      rdata_valid_q <= 1'b0;
      error_q       <= 3'd0;
      if (!dmactive_i) begin
        state_q <= SbIdle; // module inactive, drop everything
      end else begin
        case (state_q)
          SbIdle: if (sb_cmd_i.start) state_q <= SbReq;
          SbReq:  if (master_gnt_i) state_q <= SbWait;
          SbWait: begin
            if (master_r_valid_i) begin
              state_q       <= SbIdle;
              rdata_valid_q <= ~we_q & ~master_r_err_i;
              error_q       <= master_r_err_i ? SbErrBus : 3'd0;
            end
          end
          default: state_q <= SbIdle;
        endcase
      end
    end
  end

  // command and read data payload
  always_ff @(posedge clk_i) begin
    if (state_q == SbIdle && sb_cmd_i.start) begin
      addr_q  <= sb_cmd_i.address;
      wdata_q <= sb_cmd_i.wdata;
      we_q    <= sb_cmd_i.write;
    end
    if (state_q == SbWait && master_r_valid_i) rdata_q <= master_r_rdata_i;
  end

  assign master_req_o   = (state_q == SbReq);
  assign master_add_o   = addr_q;
  assign master_we_o    = we_q;
  assign master_wdata_o = wdata_q;

  assign sb_status_o = '{rdata:       rdata_q,
                         rdata_valid: rdata_valid_q,
                         busy:        (state_q != SbIdle),
                         error:       error_q};

  // csr block must hold off while an access runs
  a_no_start_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sb_cmd_i.start |-> state_q == SbIdle);

  a_req_until_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i || !dmactive_i)
    master_req_o && !master_gnt_i |=> master_req_o);

endmodule

// ==== design/dm_hart_ctrl.sv ====
`timescale 1ns/100ps

module dm_hart_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        dmactive_i,
  input  logic [dm_pkg::HartSelW-1:0] hartsel_i,
  input  logic                        haltreq_i,
  input  logic                        resumereq_i,
  output logic [dm_pkg::NrHarts-1:0]  halted_o,
  output logic [dm_pkg::NrHarts-1:0]  resumeack_o,
  output logic [dm_pkg::NrHarts-1:0]  debug_req_o,
  input  logic                        slave_req_i,
  input  logic                        slave_we_i,
  input  logic [31:0]                 slave_addr_i,
  input  logic [31:0]                 slave_wdata_i,
  output logic [31:0]                 slave_rdata_o,
  output logic                        slave_err_o
);
  import dm_pkg::*;

  logic [NrHarts-1:0]  halted_q, resumeack_q, going_q;
  logic [HartSelW-1:0] hart_id;
  logic                addr_ok;
  logic [31:0]         rdata_q;
  logic                err_q;

  assign hart_id = slave_wdata_i[HartSelW-1:0];
  assign addr_ok = (slave_addr_i == HaltedAddr) || (slave_addr_i == ResumingAddr) ||
                   (slave_addr_i == FlagsAddr);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      halted_q    <= '0;
      resumeack_q <= '0;
      going_q     <= '0;
      err_q       <= 1'b0;
    end else if (!dmactive_i) begin
      halted_q    <= '0;
      resumeack_q <= '0;
      going_q     <= '0;
      err_q       <= 1'b0;
    end else begin
      err_q <= slave_req_i & ~addr_ok;
      // resume only makes sense for a halted hart
      if (resumereq_i) begin
        resumeack_q[hartsel_i] <= 1'b0;
        if (halted_q[hartsel_i]) going_q[hartsel_i] <= 1'b1;
      end
      if (slave_req_i && slave_we_i) begin
        if (slave_addr_i == HaltedAddr) begin
          halted_q[hart_id] <= 1'b1;
          going_q[hart_id]  <= 1'b0;
        end else if (slave_addr_i == ResumingAddr) begin
          halted_q[hart_id]    <= 1'b0;
          resumeack_q[hart_id] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (slave_req_i && !slave_we_i) begin
      rdata_q <= (slave_addr_i == FlagsAddr) ? {{(32 - NrHarts){1'b0}}, going_q} : 32'd0;
    end
  end

  always_comb begin
    for (int h = 0; h < NrHarts; h++) begin
      debug_req_o[h] = dmactive_i & haltreq_i & (hartsel_i == HartSelW'(h));
    end
  end

  assign halted_o      = halted_q;
  assign resumeack_o   = resumeack_q;
  assign slave_rdata_o = rdata_q;
  assign slave_err_o   = err_q;

endmodule

// ==== design/dm_top.sv ====
`timescale 1ns/100ps

module dm_top (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  output logic                       dmactive_o,
  output logic [dm_pkg::NrHarts-1:0] debug_req_o,

  input  logic                       slave_req_i,
  input  logic                       slave_we_i,
  input  logic [31:0]                slave_addr_i,
  input  logic [31:0]                slave_wdata_i,
  output logic [31:0]                slave_rdata_o,
  output logic                       slave_err_o,

  output logic                       master_req_o,
  output logic [31:0]                master_add_o,
  output logic                       master_we_o,
  output logic [31:0]                master_wdata_o,
  input  logic                       master_gnt_i,
  input  logic                       master_r_valid_i,
  input  logic                       master_r_err_i,
  input  logic [31:0]                master_r_rdata_i,

  input  logic                       dmi_req_valid_i,
  output logic                       dmi_req_ready_o,
  input  dm_pkg::dmi_req_t           dmi_req_i,
  output logic                       dmi_resp_valid_o,
  input  logic                       dmi_resp_ready_i,
  output dm_pkg::dmi_resp_t          dmi_resp_o
);
  import dm_pkg::*;

  logic [HartSelW-1:0] hartsel;
  logic                haltreq, resumereq;
  logic [NrHarts-1:0]  halted, resumeack;
  sb_cmd_t             sb_cmd;
  sb_status_t          sb_status;

  dm_csrs i_dm_csrs (
    .clk_i,
    .rst_n_i,
    .dmi_req_valid_i,
    .dmi_req_ready_o,
    .dmi_req_i,
    .dmi_resp_valid_o,
    .dmi_resp_ready_i,
    .dmi_resp_o,
    .dmactive_o,
    .hartsel_o   ( hartsel   ),
    .haltreq_o   ( haltreq   ),
    .resumereq_o ( resumereq ),
    .halted_i    ( halted    ),
    .resumeack_i ( resumeack ),
    .sb_cmd_o    ( sb_cmd    ),
    .sb_status_i ( sb_status )
  );

  dm_sba i_dm_sba (
    .clk_i,
    .rst_n_i,
    .dmactive_i  ( dmactive_o ),
    .sb_cmd_i    ( sb_cmd     ),
    .sb_status_o ( sb_status  ),
    .master_req_o,
    .master_add_o,
    .master_we_o,
    .master_wdata_o,
    .master_gnt_i,
    .master_r_valid_i,
    .master_r_err_i,
    .master_r_rdata_i
  );

  dm_hart_ctrl i_dm_hart_ctrl (
    .clk_i,
    .rst_n_i,
    .dmactive_i  ( dmactive_o ),
    .hartsel_i   ( hartsel    ),
    .haltreq_i   ( haltreq    ),
    .resumereq_i ( resumereq  ),
    .halted_o    ( halted     ),
    .resumeack_o ( resumeack  ),
    .debug_req_o,
    .slave_req_i,
    .slave_we_i,
    .slave_addr_i,
    .slave_wdata_i,
    .slave_rdata_o,
    .slave_err_o
  );

endmodule

// ==== tb/tb_dm_top.sv ====
`timescale 1ns/100ps

module tb_dm_top;
  import dm_pkg::*;

  typedef logic [8*24-1:0] name_t;

  localparam int unsigned MaxWait = 100; // cycles or polls per wait

  logic               clk_i = 1'b0;
  logic               rst_n_i;
  logic               dmactive_o;
  logic [NrHarts-1:0] debug_req_o;
  logic               slave_req_i, slave_we_i;
  logic [31:0]        slave_addr_i, slave_wdata_i, slave_rdata_o;
  logic               slave_err_o;
  logic               master_req_o, master_we_o;
  logic [31:0]        master_add_o, master_wdata_o, master_r_rdata_i;
  logic               master_gnt_i, master_r_valid_i, master_r_err_i;
  logic               dmi_req_valid_i, dmi_req_ready_o;
  dmi_req_t           dmi_req_i;
  logic               dmi_resp_valid_o, dmi_resp_ready_i;
  dmi_resp_t          dmi_resp_o;

  int unsigned errors = 0;
  int unsigned checks = 0;
  logic        timed_out = 1'b0;
  logic [31:0] rng_state = 32'ha3a30bbf;
  logic [31:0] last_wr_addr = '0;
  logic [31:0] last_wr_data = '0;

  dm_top dut (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x ^ (x << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic check_value(input name_t name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Fail %0s: expected %08h, got %08h", name, expected, actual);
    end
  endtask

  task automatic report_timeout(input name_t name, input string what);
    errors++;
    timed_out = 1'b1;
    $display("case %0s timed out while waiting for %0s", name, what);
  endtask

  // one dmi transfer with the response held back for stall cycles
  task automatic dmi_access(input name_t name, input dtm_op_e kind, input logic [6:0] addr,
                            input logic [31:0] data, input int unsigned stall,
                            output logic [31:0] rdata);
    int unsigned n;
    dmi_resp_t   held;
    n = 0;
    rdata = '0;
    @(negedge clk_i);
    while (!dmi_req_ready_o && n < MaxWait) begin
      @(negedge clk_i);
      n++;
    end
    if (!dmi_req_ready_o) begin
      report_timeout(name, "the DMI request to be ready");
      return;
    end
    dmi_req_valid_i  = 1'b1;
    dmi_req_i        = '{addr: addr, op: kind, data: data};
    dmi_resp_ready_i = (stall == 0);
    @(negedge clk_i); // accepted on the edge just passed
    dmi_req_valid_i = 1'b0;
    if (!dmi_resp_valid_o) begin
      errors++;
      $display("case %0s got no DMI response one cycle after acceptance", name);
    end
    held = dmi_resp_o;
    for (n = 0; n < stall; n++) begin
      @(negedge clk_i);
      check_value(name, held.data, dmi_resp_o.data);
      if (!dmi_resp_valid_o) begin
        errors++;
        $display("case %0s lost its DMI response while it was stalled", name);
      end
    end
    dmi_resp_ready_i = 1'b1;
    check_value(name, 32'd0, 32'(held.resp));
    rdata = held.data;
  endtask

  // hart model with one strobe per access
  task automatic slave_write(input logic [31:0] addr, input logic [31:0] data);
    @(negedge clk_i);
    slave_req_i   = 1'b1;
    slave_we_i    = 1'b1;
    slave_addr_i  = addr;
    slave_wdata_i = data;
    @(negedge clk_i);
    slave_req_i = 1'b0;
    slave_we_i  = 1'b0;
  endtask

  task automatic slave_read(input name_t name, input logic [31:0] addr,
                            input logic [31:0] expected, input logic bad);
    @(negedge clk_i);
    slave_req_i  = 1'b1;
    slave_we_i   = 1'b0;
    slave_addr_i = addr;
    @(negedge clk_i);
    slave_req_i = 1'b0;
    check_value(name, expected, slave_rdata_o);
    check_value(name, {31'b0, bad}, {31'b0, slave_err_o});
  endtask

  // poll sbcs until sbbusy drops
  task automatic wait_sb_idle(input name_t name);
    logic [31:0] sbcs;
    int unsigned n;
    n = 0;
    dmi_access(name, DtmRead, SbcsAddr, '0, 0, sbcs);
    while (sbcs[21] && n < MaxWait && !timed_out) begin
      dmi_access(name, DtmRead, SbcsAddr, '0, 0, sbcs);
      n++;
    end
    if (sbcs[21] && !timed_out) report_timeout(name, "sbcs busy to clear");
  endtask

  task automatic run_case(input name_t op, input name_t name, input logic [31:0] addr,
                          input logic [31:0] wdata, input logic [31:0] expected);
    logic [31:0] rdata;
    logic        bad;
    bad = !(addr == HaltedAddr || addr == ResumingAddr || addr == FlagsAddr);
    case (op)
      name_t'("dw"): begin
        dmi_access(name, DtmWrite, addr[6:0], wdata, 0, rdata);
        // dmactive follows bit 0 of every dmcontrol write
        if (addr[6:0] == DmControlAddr) begin
          check_value(name, {31'b0, wdata[0]}, {31'b0, dmactive_o});
        end
      end
      name_t'("dr"): begin
        dmi_access(name, DtmRead, addr[6:0], wdata, 0, rdata);
        check_value(name, expected, rdata);
      end
      name_t'("ds"): begin
        dmi_access(name, DtmRead, addr[6:0], wdata, 3, rdata);
        check_value(name, expected, rdata);
      end
      name_t'("dbg"): begin
        @(negedge clk_i);
        check_value(name, expected, 32'(debug_req_o));
      end
      name_t'("hw"):  slave_write(addr, wdata);
      name_t'("hr"):  slave_read(name, addr, expected, bad);
      name_t'("sbw"): wait_sb_idle(name);
      name_t'("mw"): begin
        check_value(name, addr, last_wr_addr);
        check_value(name, expected, last_wr_data);
      end
      default: begin
        errors++;
        $display("case %0s has an unknown operation %0s", name, op);
      end
    endcase
  endtask

  // memory model with random grant and response delay
  initial begin
    master_gnt_i     = 1'b0;
    master_r_valid_i = 1'b0;
    master_r_err_i   = 1'b0;
    master_r_rdata_i = '0;
    forever begin
      @(negedge clk_i);
      master_gnt_i     = 1'b0;
      master_r_valid_i = 1'b0;
      master_r_err_i   = 1'b0;
      if (rst_n_i && master_req_o) begin
        rng_state = xorshift(rng_state);
        repeat (rng_state[1:0]) @(negedge clk_i);
        master_gnt_i = 1'b1;
        if (master_we_o) begin
          last_wr_addr = master_add_o;
          last_wr_data = master_wdata_o;
        end
        @(negedge clk_i);
        master_gnt_i = 1'b0;
        repeat (rng_state[3:2]) @(negedge clk_i);
        master_r_valid_i = 1'b1;
        master_r_err_i   = (master_add_o >= 32'hf000_0000); // upper region unmapped
        master_r_rdata_i = master_add_o ^ 32'h5a5a_0000;
      end
    end
  end

  initial begin
    int               fd;
    int               code;
    name_t            op, name;
    logic [31:0]      addr, wdata, expected;
    logic [8*128-1:0] rest;
    rst_n_i          = 1'b0;
    dmi_req_valid_i  = 1'b0;
    dmi_req_i        = '0;
    dmi_resp_ready_i = 1'b1;
    slave_req_i      = 1'b0;
    slave_we_i       = 1'b0;
    slave_addr_i     = '0;
    slave_wdata_i    = '0;
    repeat (10) @(negedge clk_i);
    rst_n_i = 1'b1;

    // everything idle and low after reset, only the request side ready
    check_value(name_t'("reset_state"), 32'h1,
                32'({dmactive_o, debug_req_o, slave_err_o, master_req_o,
                     dmi_resp_valid_o, dmi_req_ready_o}));

    fd = $fopen("tb/dm_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open tb/dm_cases.txt");
    end else begin
      while (!timed_out && $fscanf(fd, "%s", op) == 1) begin
        if (op == name_t'("#")) begin
          code = $fgets(rest, fd); // skip comment line
        end else begin
          code = $fscanf(fd, "%s %h %h %h", name, addr, wdata, expected);
          if (code != 4) begin
            errors++;
            $display("malformed line in the case file at operation %0s", op);
          end else begin
            run_case(op, name, addr, wdata, expected);
          end
        end
      end
      $fclose(fd);
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== tb/dm_cases.txt ====
# op name addr wdata expected (hex numbers)
# dw/dr/ds dmi write, read, stalled read; hw/hr hart port; dbg; sbw wait sba; mw master write
dw data0_wr 04 11223344 0
ds data0_rd 04 0 11223344
dw sbaddr_wr 39 00001230 0
dr sbaddr_rd 39 0 00001230
dw halt_h1 10 80010001 0
dr dmctl_rd 10 0 80010001
dbg dbgreq_h1 0 0 2
dr status_run 11 0 00000c82
hw hart_halt 100 1 0
dr status_halt 11 0 00000382
dw resume_h1 10 40010001 0
dbg dbgreq_off 0 0 0
hr going_rd 400 0 2
hw hart_resume 108 1 0
dr status_ack 11 0 00030c82
dw sbcs_rdonaddr 38 00100000 0
dr sbcs_rd 38 0 20140404
dw sb_rd_addr 39 00002468 0
sbw sb_rd_wait 0 0 0
dr sb_rd_data 3c 0 5a5a2468
dw sb_wr_data 3c cafef00d 0
sbw sb_wr_wait 0 0 0
mw sb_wr_bus 2468 0 cafef00d
dw sb_bad_addr 39 f0000010 0
sbw sb_bad_wait 0 0 0
dr sbcs_err 38 0 20142404
dw sbcs_clr 38 00107000 0
dr sbcs_clr_rd 38 0 20140404
hr bad_slave 200 0 0

// ==== project.f ====
common/dm_pkg.sv
csrs/dm_csrs.sv
sba/dm_sba.sv
design/dm_hart_ctrl.sv
design/dm_top.sv
tb/tb_dm_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the debug module testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f project.f --top-module tb_dm_top -o tb_dm_top

output=$(./obj_dir/tb_dm_top)
echo "$output"

if echo "$output" | grep -q "Verification passed"; then
  exit 0
else
  exit 1
fi
